// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FLIST     ?= mips_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== mips_core.f ====
mips_pkg.sv
mips_inst_port.sv
mips_decode.sv
mips_execute.sv
mips_result.sv
mips_core.sv
tb_mips_core.sv

// ==== mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      inst_req_i,
    input  logic [mips_pkg::XLEN-1:0] inst_i,
    output logic                      inst_ack_o,
    output mips_pkg::wb_t             wb_o
);
    import mips_pkg::*;

    logic                  take;
    logic [XLEN-1:0]       inst;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    ex_req_t               ex_req;
    wb_t                   ex_wb;

    mips_inst_port mips_inst_port_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .take_o     (take),
        .inst_o     (inst)
    );

    mips_decode mips_decode_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .take_i    (take),
        .inst_i    (inst),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .ex_req_o  (ex_req)
    );

    mips_execute mips_execute_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ex_req_i (ex_req),
        .wb_o     (ex_wb)
    );

    mips_result mips_result_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_i      (ex_wb),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wb_o      (wb_o)
    );

endmodule

// ==== mips_decode.sv ====
`timescale 1ns/1ps

module mips_decode (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            take_i,
    input  logic [mips_pkg::XLEN-1:0]       inst_i,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_o,
    input  logic [mips_pkg::XLEN-1:0]       rs_data_i,
    input  logic [mips_pkg::XLEN-1:0]       rt_data_i,
    output mips_pkg::ex_req_t               ex_req_o
);
    import mips_pkg::*;

    logic                  valid_q;
    logic [XLEN-1:0]       inst_q;

    op_e                   op;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SHAMT_W-1:0]    shamt;
    logic [IMM_W-1:0]      imm;

    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_zext;
    logic [XLEN-1:0]       imm_upper;
    logic [XLEN-1:0]       shamt_zext;

    alu_op_e               alu_op;
    logic [XLEN-1:0]       src_a;
    logic [XLEN-1:0]       src_b;
    logic [REG_ADDR_W-1:0] dest;
    logic                  known;
    logic                  wr_cond;  // movn/movz rt test

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= take_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take_i) begin
            inst_q <= inst_i;
        end
    end

    // field split
    assign op    = op_e'(inst_q[OP_LSB +: OP_W]);
    assign funct = funct_e'(inst_q[FUNCT_LSB +: FUNCT_W]);
    assign rs    = inst_q[RS_LSB +: REG_ADDR_W];
    assign rt    = inst_q[RT_LSB +: REG_ADDR_W];
    assign rd    = inst_q[RD_LSB +: REG_ADDR_W];
    assign shamt = inst_q[SHAMT_LSB +: SHAMT_W];
    assign imm   = inst_q[IMM_LSB +: IMM_W];

    assign imm_sext   = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign imm_zext   = {{(XLEN-IMM_W){1'b0}}, imm};
    assign imm_upper  = {imm, {(XLEN-IMM_W){1'b0}}};  // lui
    assign shamt_zext = {{(XLEN-SHAMT_W){1'b0}}, shamt};

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    always_comb begin
        alu_op  = ALU_OR;
        src_a   = rs_data_i;
        src_b   = rt_data_i;
        dest    = rd;
        known   = 1'b1;
        wr_cond = 1'b1;
        case (op)
            SPECIAL: begin
                case (funct)
                    SLL: begin
                        alu_op = ALU_SLL;
                        src_a  = shamt_zext;
                    end
                    SRL: begin
                        alu_op = ALU_SRL;
                        src_a  = shamt_zext;
                    end
                    SRA: begin
                        alu_op = ALU_SRA;
                        src_a  = shamt_zext;
                    end
                    SLLV:      alu_op = ALU_SLL;
                    SRLV:      alu_op = ALU_SRL;
                    SRAV:      alu_op = ALU_SRA;
                    MOVZ: begin
                        alu_op  = ALU_MOVE;
                        wr_cond = (rt_data_i == '0);
                    end
                    MOVN: begin
                        alu_op  = ALU_MOVE;
                        wr_cond = (rt_data_i != '0);
                    end
                    ADD, ADDU: alu_op = ALU_ADD;  // no overflow trap
                    SUB, SUBU: alu_op = ALU_SUB;
                    AND:       alu_op = ALU_AND;
                    OR:        alu_op = ALU_OR;
                    XOR:       alu_op = ALU_XOR;
                    NOR:       alu_op = ALU_NOR;
                    SLT:       alu_op = ALU_SLT;
                    SLTU:      alu_op = ALU_SLTU;
                    default:   known  = 1'b0;
                endcase
            end
            ADDI, ADDIU: begin
                alu_op = ALU_ADD;
                src_b  = imm_sext;
                dest   = rt;
            end
            SLTI: begin
                alu_op = ALU_SLT;
                src_b  = imm_sext;
                dest   = rt;
            end
            SLTIU: begin
                alu_op = ALU_SLTU;
                src_b  = imm_sext;  // sign-extended, compared unsigned
                dest   = rt;
            end
            ANDI: begin
                alu_op = ALU_AND;
                src_b  = imm_zext;
                dest   = rt;
            end
            ORI: begin
                alu_op = ALU_OR;
                src_b  = imm_zext;
                dest   = rt;
            end
            XORI: begin
                alu_op = ALU_XOR;
                src_b  = imm_zext;
                dest   = rt;
            end
            LUI: begin
                alu_op = ALU_OR;
                src_a  = '0;
                src_b  = imm_upper;
                dest   = rt;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        ex_req_o.valid  = valid_q;
        ex_req_o.alu_op = alu_op;
        ex_req_o.src_a  = src_a;
        ex_req_o.src_b  = src_b;
        ex_req_o.dest   = dest;
        ex_req_o.wreg   = known && wr_cond && (dest != '0);  // $0 never written
    end

    // encoded target field, rd for SPECIAL and rt otherwise
    a_no_wreg_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        ex_req_o.valid && ex_req_o.wreg |-> ((op == SPECIAL) ? rd : rt) != '0);

endmodule

// ==== mips_execute.sv ====
`timescale 1ns/1ps

module mips_execute (
    input  logic              clk,
    input  logic              arst_n_i,
    input  mips_pkg::ex_req_t ex_req_i,
    output mips_pkg::wb_t     wb_o
);
    import mips_pkg::*;

    ex_req_t            req_q;
    logic [SHAMT_W-1:0] sh;
    logic [XLEN-1:0]    result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= '0;
        end else begin
            req_q <= ex_req_i;
        end
    end

    assign sh = req_q.src_a[SHAMT_W-1:0];  // shamt or rs[4:0]

    always_comb begin
        case (req_q.alu_op)
            ALU_OR:   result = req_q.src_a | req_q.src_b;
            ALU_AND:  result = req_q.src_a & req_q.src_b;
            ALU_XOR:  result = req_q.src_a ^ req_q.src_b;
            ALU_NOR:  result = ~(req_q.src_a | req_q.src_b);
            ALU_SLL:  result = req_q.src_b << sh;
            ALU_SRL:  result = req_q.src_b >> sh;
            ALU_SRA:  result = $signed(req_q.src_b) >>> sh;
            ALU_ADD:  result = req_q.src_a + req_q.src_b;  // wraps
            ALU_SUB:  result = req_q.src_a - req_q.src_b;
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, ($signed(req_q.src_a) < $signed(req_q.src_b))};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, (req_q.src_a < req_q.src_b)};
            end
            ALU_MOVE: result = req_q.src_a;
            default:  result = '0;
        endcase
    end

    always_comb begin
        wb_o.valid = req_q.valid && req_q.wreg;
        wb_o.addr  = req_q.dest;
        wb_o.data  = result;
    end

    // decode must only hand over real ALU ops
    a_alu_op_defined: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_q.valid |-> !$isunknown(req_q.alu_op) && (req_q.alu_op <= ALU_MOVE));

endmodule

// ==== mips_inst_port.sv ====
`timescale 1ns/1ps

module mips_inst_port (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      inst_req_i,
    input  logic [mips_pkg::XLEN-1:0] inst_i,
    output logic                      inst_ack_o,
    output logic                      take_o,
    output logic [mips_pkg::XLEN-1:0] inst_o
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,   // first ack cycle
        HS_WAIT   // ack held until req drops
    } hs_state_e;

    hs_state_e state_q;
    hs_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            HS_IDLE: begin
                if (inst_req_i) begin
                    state_d = HS_ACK;
                end
            end
            HS_ACK: begin
                state_d = inst_req_i ? HS_WAIT : HS_IDLE;
            end
            HS_WAIT: begin
                if (!inst_req_i) begin
                    state_d = HS_IDLE;
                end
            end
            default: state_d = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= HS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign inst_ack_o = (state_q != HS_IDLE);
    assign take_o     = (state_q == HS_IDLE) && inst_req_i;  // capture edge
    assign inst_o     = inst_i;

    // an ack edge needs a request standing at the capture edge
    a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(inst_ack_o) |-> $past(inst_req_i));

endmodule

// ==== mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;
    localparam int OP_W       = 6;
    localparam int FUNCT_W    = 6;

    // lsb of each instruction field
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_LSB   = 0;

    // primary opcode, bits 31:26
    typedef enum logic [OP_W-1:0] {
        SPECIAL = 6'h00,
        ADDI    = 6'h08,
        ADDIU   = 6'h09,
        SLTI    = 6'h0a,
        SLTIU   = 6'h0b,
        ANDI    = 6'h0c,
        ORI     = 6'h0d,
        XORI    = 6'h0e,
        LUI     = 6'h0f
    } op_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [FUNCT_W-1:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        SLLV = 6'h04,
        SRLV = 6'h06,
        SRAV = 6'h07,
        MOVZ = 6'h0a,
        MOVN = 6'h0b,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a,
        SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_OR   = 4'd0,
        ALU_AND  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_NOR  = 4'd3,
        ALU_SLL  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_SRA  = 4'd6,
        ALU_ADD  = 4'd7,
        ALU_SUB  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10,
        ALU_MOVE = 4'd11  // passes src_a
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;
        logic [REG_ADDR_W-1:0] dest;
        logic                  wreg;
    } ex_req_t;

    // register write-back
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// ==== mips_result.sv ====
`timescale 1ns/1ps

module mips_result (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  mips_pkg::wb_t                   wb_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_i,
    output logic [mips_pkg::XLEN-1:0]       rs_data_o,
    output logic [mips_pkg::XLEN-1:0]       rt_data_o,
    output mips_pkg::wb_t                   wb_o
);
    import mips_pkg::*;

    logic                  valid_q;
    logic [REG_ADDR_W-1:0] addr_q;
    logic [XLEN-1:0]       data_q;
    logic [XLEN-1:0]       regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            valid_q <= wb_i.valid;
            if (wb_i.valid) begin
                regs[wb_i.addr] <= wb_i.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= wb_i.addr;
        data_q <= wb_i.data;
    end

    // $0 stays zero, decode never targets it
    assign rs_data_o = regs[rs_addr_i];
    assign rt_data_o = regs[rt_addr_i];

    always_comb begin
        wb_o.valid = valid_q;
        wb_o.addr  = addr_q;
        wb_o.data  = data_q;
    end

    // handshake spacing keeps write-backs apart
    a_wb_spaced: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_q |=> !valid_q);

endmodule

// ==== tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int MAX_CYCLES = 3000;

    logic                  clk;
    logic                  arst_n_i;
    logic                  inst_req_i;
    logic [XLEN-1:0]       inst_i;
    logic                  inst_ack_o;
    wb_t                   wb_o;

    logic [XLEN-1:0]       model [NUM_REGS];  // shadow register file
    int                    errors;
    int                    passed;
    int                    failed;
    int                    cycles;

    mips_core mips_core_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .wb_o       (wb_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [XLEN-1:0] r_type(input funct_e fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sa);
        return {SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [XLEN-1:0] i_type(input op_e op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [IMM_W-1:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [XLEN-1:0] sext(input logic [IMM_W-1:0] imm);
        return {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

    task automatic check_val(input string name, input logic [XLEN-1:0] act,
                             input logic [XLEN-1:0] exp);
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // one four-phase exchange, then the write-back two edges after ack
    task automatic send(input logic [XLEN-1:0] word, input logic exp_wr,
                        input logic [REG_ADDR_W-1:0] exp_addr, input logic [XLEN-1:0] exp_data);
        @(negedge clk);
        assert (!inst_ack_o) else begin
            $display("ack still high at %0t before a new request", $time);
            errors++;
        end
        inst_req_i = 1'b1;
        inst_i     = word;
        @(negedge clk);
        while (!inst_ack_o) @(negedge clk);
        inst_req_i = 1'b0;
        @(negedge clk);
        assert (!inst_ack_o) else begin
            $display("ack did not fall at %0t after the request dropped", $time);
            errors++;
        end
        @(negedge clk);
        check_val("wb_o.valid", XLEN'(wb_o.valid), XLEN'(exp_wr));
        if (exp_wr) begin
            check_val("wb_o.addr", XLEN'(wb_o.addr), XLEN'(exp_addr));
            check_val("wb_o.data", wb_o.data, exp_data);
            model[exp_addr] = exp_data;
        end
        @(negedge clk);
        assert (!wb_o.valid) else begin
            $display("a second write-back appeared at %0t for one request", $time);
            errors++;
        end
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [XLEN-1:0] value);
        send(i_type(LUI, 5'd0, r, value[31:16]), 1'b1, r, {value[31:16], 16'h0000});
        send(i_type(ORI, r, r, value[15:0]), 1'b1, r, value);
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic reset_handshake_test();
        int start;
        int n_wb;
        start = errors;
        n_wb  = 0;
        check_val("inst_ack_o", XLEN'(inst_ack_o), '0);
        check_val("wb_o.valid", XLEN'(wb_o.valid), '0);
        inst_req_i = 1'b1;
        inst_i     = i_type(ORI, 5'd0, 5'd1, 16'h00a5);
        @(negedge clk);
        while (!inst_ack_o) @(negedge clk);
        for (int i = 0; i < 4; i++) begin  // req held, ack must stay
            assert (inst_ack_o) else begin
                $display("ack fell at %0t while req was still high", $time);
                errors++;
            end
            if (wb_o.valid) begin
                n_wb++;
                check_val("wb_o.data", wb_o.data, 32'h0000_00a5);
            end
            @(negedge clk);
        end
        inst_req_i = 1'b0;
        @(negedge clk);
        check_val("inst_ack_o", XLEN'(inst_ack_o), '0);
        repeat (3) begin
            if (wb_o.valid) n_wb++;
            @(negedge clk);
        end
        check_val("write-back count", n_wb, 32'd1);
        model[1] = 32'h0000_00a5;
        report_test("reset_handshake", start);
    endtask

    task automatic imm_logic_test();
        int               start;
        logic [IMM_W-1:0] imm;
        start = errors;
        for (int k = 0; k < 4; k++) begin
            load_reg(5'd2, $urandom);
            imm = IMM_W'($urandom) | 16'h8000;  // top bit set, zero-extended
            send(i_type(ANDI, 5'd2, 5'd3, imm), 1'b1, 5'd3, model[2] & {16'h0000, imm});
            send(i_type(XORI, 5'd2, 5'd4, imm), 1'b1, 5'd4, model[2] ^ {16'h0000, imm});
        end
        report_test("imm_logic", start);
    endtask

    task automatic logic_shifts_test();
        int         start;
        logic [4:0] sa;
        start = errors;
        load_reg(5'd5, $urandom);
        load_reg(5'd6, $urandom | 32'h8000_0000);  // negative for sra
        sa = 5'($urandom);
        send(r_type(OR, 5'd5, 5'd6, 5'd7, 5'd0), 1'b1, 5'd7, model[5] | model[6]);
        send(r_type(AND, 5'd5, 5'd6, 5'd7, 5'd0), 1'b1, 5'd7, model[5] & model[6]);
        send(r_type(XOR, 5'd5, 5'd6, 5'd7, 5'd0), 1'b1, 5'd7, model[5] ^ model[6]);
        send(r_type(NOR, 5'd5, 5'd6, 5'd7, 5'd0), 1'b1, 5'd7, ~(model[5] | model[6]));
        send(r_type(SLL, 5'd0, 5'd6, 5'd8, sa), 1'b1, 5'd8, model[6] << sa);
        send(r_type(SRL, 5'd0, 5'd6, 5'd8, sa), 1'b1, 5'd8, model[6] >> sa);
        send(r_type(SRA, 5'd0, 5'd6, 5'd8, sa), 1'b1, 5'd8, $signed(model[6]) >>> sa);
        send(r_type(SLLV, 5'd5, 5'd6, 5'd9, 5'd0), 1'b1, 5'd9, model[6] << model[5][4:0]);
        send(r_type(SRLV, 5'd5, 5'd6, 5'd9, 5'd0), 1'b1, 5'd9, model[6] >> model[5][4:0]);
        send(r_type(SRAV, 5'd5, 5'd6, 5'd9, 5'd0), 1'b1, 5'd9,
             $signed(model[6]) >>> model[5][4:0]);
        report_test("logic_shifts", start);
    endtask

    task automatic arith_test();
        int start;
        start = errors;
        load_reg(5'd11, 32'hffff_fff0);  // -16
        load_reg(5'd12, 32'h0000_0020);
        send(r_type(ADD, 5'd11, 5'd12, 5'd13, 5'd0), 1'b1, 5'd13, model[11] + model[12]);
        send(r_type(ADDU, 5'd11, 5'd11, 5'd13, 5'd0), 1'b1, 5'd13, model[11] + model[11]);
        send(r_type(SUB, 5'd12, 5'd11, 5'd14, 5'd0), 1'b1, 5'd14, model[12] - model[11]);
        send(r_type(SUBU, 5'd0, 5'd12, 5'd14, 5'd0), 1'b1, 5'd14, 32'd0 - model[12]);
        send(i_type(ADDI, 5'd11, 5'd15, 16'hfff8), 1'b1, 5'd15, model[11] + sext(16'hfff8));
        send(i_type(ADDIU, 5'd12, 5'd15, 16'h8001), 1'b1, 5'd15, model[12] + sext(16'h8001));
        send(r_type(SLT, 5'd11, 5'd12, 5'd16, 5'd0), 1'b1, 5'd16,
             XLEN'($signed(model[11]) < $signed(model[12])));
        send(r_type(SLTU, 5'd11, 5'd12, 5'd16, 5'd0), 1'b1, 5'd16,
             XLEN'(model[11] < model[12]));
        send(i_type(SLTI, 5'd11, 5'd17, 16'h0001), 1'b1, 5'd17,
             XLEN'($signed(model[11]) < $signed(sext(16'h0001))));
        send(i_type(SLTIU, 5'd11, 5'd17, 16'h0001), 1'b1, 5'd17,
             XLEN'(model[11] < sext(16'h0001)));
        send(i_type(SLTIU, 5'd12, 5'd17, 16'hffff), 1'b1, 5'd17,
             XLEN'(model[12] < sext(16'hffff)));
        report_test("arith", start);
    endtask

    task automatic moves_suppressed_test();
        int start;
        start = errors;
        load_reg(5'd18, $urandom);
        load_reg(5'd19, 32'h0000_0005);
        load_reg(5'd20, 32'h0000_0000);
        send(r_type(MOVN, 5'd18, 5'd19, 5'd21, 5'd0), 1'b1, 5'd21, model[18]);
        send(r_type(MOVN, 5'd18, 5'd20, 5'd22, 5'd0), 1'b0, 5'd0, '0);
        send(r_type(MOVZ, 5'd18, 5'd20, 5'd22, 5'd0), 1'b1, 5'd22, model[18]);
        send(r_type(MOVZ, 5'd18, 5'd19, 5'd21, 5'd0), 1'b0, 5'd0, '0);
        send(i_type(ORI, 5'd18, 5'd0, 16'h0077), 1'b0, 5'd0, '0);
        send({6'h3f, 5'd18, 5'd23, 16'h1234}, 1'b0, 5'd0, '0);  // unknown opcode
        send(r_type(OR, 5'd0, 5'd0, 5'd23, 5'd0), 1'b1, 5'd23, 32'd0);
        send(r_type(OR, 5'd0, 5'd18, 5'd24, 5'd0), 1'b1, 5'd24, model[18]);
        report_test("moves_suppressed", start);
    endtask

    initial begin
        clk        = 1'b0;
        arst_n_i   = 1'b0;
        inst_req_i = 1'b0;
        inst_i     = '0;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        cycles     = 0;
        for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
        void'($urandom(32'h8cdd_5b65));
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        reset_handshake_test();
        imm_logic_test();
        logic_shifts_test();
        arith_test();
        moves_suppressed_test();
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
